//--- rtl/feat_pkg.sv
package feat_pkg;

    // image geometry
    localparam int img_w = 16;
    localparam int img_h = 16;
    localparam int pix_w = 8;
    localparam int row_w = pix_w * img_w;

    localparam int row_addr_w = 4;
    localparam int col_w = 4;

    // keypoint store, one slot per pixel
    localparam int kpt_depth = img_w * img_h;
    localparam int kpt_addr_w = 8;
    localparam int kpt_w = row_addr_w + col_w;     // {row, col}
    localparam int cnt_w = 9;

    localparam int resp_w = 10;                    // signed response

    // one image row, as a raw word or as pixels
    typedef union packed {
        logic [row_w-1:0] flat;
        logic [img_w-1:0][pix_w-1:0] pix;         // pix[0] is column 0
    } row_word_t;

    typedef enum logic [2:0] {
        ph_idle   = 3'd0,
        ph_blur   = 3'd1,
        ph_detect = 3'd2,
        ph_done   = 3'd3
    } phase_t;

endpackage

//--- rtl/row_mem.sv
module row_mem #(
    parameter int data_w = feat_pkg::row_w,
    parameter int depth = feat_pkg::img_h
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] addr,
    input  logic [data_w-1:0]        din,
    output logic [data_w-1:0]        dout
);

    logic [data_w-1:0] mem [depth];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= din;
        end
        dout <= mem[addr];    // read before write
    end

endmodule

//--- rtl/line_buffer.sv
module line_buffer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                shift,
    input  logic                fill_zero,
    input  feat_pkg::row_word_t row_in,
    output feat_pkg::row_word_t row_top,
    output feat_pkg::row_word_t row_mid,
    output feat_pkg::row_word_t row_bot
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row_top.flat <= '0;
            row_mid.flat <= '0;
            row_bot.flat <= '0;
        end else if (shift) begin
            row_top.flat <= row_mid.flat;
            row_mid.flat <= row_bot.flat;
            if (fill_zero) begin
                row_bot.flat <= '0;    // padding row above or below the image
            end else begin
                row_bot.flat <= row_in.flat;
            end
        end
    end

endmodule

//--- rtl/gaussian_blur.sv
module gaussian_blur #(
    parameter int img_w = feat_pkg::img_w,
    parameter int img_h = feat_pkg::img_h
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            blur_start,
    input  feat_pkg::row_word_t             img_dout,
    output logic [feat_pkg::row_addr_w-1:0] img_addr,
    output logic                            blur_we,
    output logic [feat_pkg::row_addr_w-1:0] blur_addr,
    output feat_pkg::row_word_t             blur_din,
    output logic                            blur_done
);

    localparam int sum_w = feat_pkg::pix_w + 4;

    localparam logic [2:0] s_idle = 3'd0;
    localparam logic [2:0] s_zero = 3'd1;
    localparam logic [2:0] s_ld0  = 3'd2;
    localparam logic [2:0] s_rd   = 3'd3;
    localparam logic [2:0] s_sh   = 3'd4;
    localparam logic [2:0] s_wr   = 3'd5;
    localparam logic [2:0] s_fin  = 3'd6;

    logic [2:0] state;
    logic [feat_pkg::row_addr_w-1:0] row_cnt;
    logic last_row;
    logic shift;
    logic fill_zero;
    feat_pkg::row_word_t row_top;
    feat_pkg::row_word_t row_mid;
    feat_pkg::row_word_t row_bot;

    line_buffer line_buffer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .shift     (shift),
        .fill_zero (fill_zero),
        .row_in    (img_dout),
        .row_top   (row_top),
        .row_mid   (row_mid),
        .row_bot   (row_bot)
    );

    assign last_row = (int'(row_cnt) == img_h - 1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= s_idle;
            row_cnt <= '0;
        end else begin
            case (state)
                s_idle: begin
                    if (blur_start) begin
                        state <= s_zero;
                    end
                end
                s_zero: state <= s_ld0;
                s_ld0: begin
                    row_cnt <= '0;
                    state <= s_rd;
                end
                s_rd: state <= s_sh;
                s_sh: state <= s_wr;
                s_wr: begin
                    if (last_row) begin
                        state <= s_fin;
                    end else begin
                        row_cnt <= row_cnt + 1'b1;
                        state <= s_rd;
                    end
                end
                s_fin: state <= s_idle;
                default: state <= s_idle;
            endcase
        end
    end

    // row 0 is fetched at address zero while the zero row goes in
    assign img_addr = (state == s_rd) ? row_cnt + 1'b1 : '0;
    assign shift = (state == s_zero) || (state == s_ld0) || (state == s_sh);
    assign fill_zero = (state == s_zero) || ((state == s_sh) && last_row);

    assign blur_we = (state == s_wr);
    assign blur_addr = row_cnt;
    assign blur_done = (state == s_fin);

    // 1 2 1 / 2 4 2 / 1 2 1 kernel, zero outside the image, sum / 16
    always_comb begin
        logic [img_w+1:0][feat_pkg::pix_w-1:0] pt;
        logic [img_w+1:0][feat_pkg::pix_w-1:0] pm;
        logic [img_w+1:0][feat_pkg::pix_w-1:0] pb;
        logic [sum_w-1:0] sum;
        pt = {{feat_pkg::pix_w{1'b0}}, row_top.pix, {feat_pkg::pix_w{1'b0}}};
        pm = {{feat_pkg::pix_w{1'b0}}, row_mid.pix, {feat_pkg::pix_w{1'b0}}};
        pb = {{feat_pkg::pix_w{1'b0}}, row_bot.pix, {feat_pkg::pix_w{1'b0}}};
        blur_din = '0;
        for (int c = 0; c < img_w; c++) begin
            sum = sum_w'(pt[c]) + sum_w'(pt[c + 2]) + sum_w'(pb[c]) + sum_w'(pb[c + 2])
                + ((sum_w'(pt[c + 1]) + sum_w'(pm[c]) + sum_w'(pm[c + 2])
                    + sum_w'(pb[c + 1])) << 1)
                + (sum_w'(pm[c + 1]) << 2);    // padded index c+1 is column c
            blur_din.pix[c] = sum[sum_w-1:4];
        end
    end

    a_blur_addr_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        blur_we |-> (int'(blur_addr) < img_h)
    );

endmodule

//--- rtl/keypoint_detect.sv
module keypoint_detect #(
    parameter int img_w = feat_pkg::img_w,
    parameter int img_h = feat_pkg::img_h
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              detect_start,
    input  logic                              filter_on,
    input  logic signed [feat_pkg::resp_w-1:0] filter_threshold,
    input  feat_pkg::row_word_t               img_dout,
    input  feat_pkg::row_word_t               blur_dout,
    output logic [feat_pkg::row_addr_w-1:0]   row_addr,
    output logic                              kpt_we,
    output logic [feat_pkg::kpt_addr_w-1:0]   kpt_addr,
    output logic [feat_pkg::kpt_w-1:0]        kpt_din,
    output logic [feat_pkg::cnt_w-1:0]        kpt_count,
    output logic                              detect_done
);

    localparam logic [2:0] s_idle = 3'd0;
    localparam logic [2:0] s_rd   = 3'd1;
    localparam logic [2:0] s_lat  = 3'd2;
    localparam logic [2:0] s_col  = 3'd3;
    localparam logic [2:0] s_fin  = 3'd4;

    logic [2:0] state;
    logic [feat_pkg::row_addr_w-1:0] row_cnt;
    logic [feat_pkg::col_w-1:0] col_cnt;
    feat_pkg::row_word_t img_row;
    feat_pkg::row_word_t blur_row;
    logic [feat_pkg::pix_w-1:0] pix;
    logic [feat_pkg::pix_w-1:0] blur_pix;
    logic signed [feat_pkg::resp_w-1:0] resp;
    logic hit;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= s_idle;
            row_cnt <= '0;
            col_cnt <= '0;
            kpt_count <= '0;
        end else begin
            if (kpt_we) begin
                kpt_count <= kpt_count + 1'b1;
            end
            case (state)
                s_idle: begin
                    if (detect_start) begin
                        row_cnt <= '0;
                        kpt_count <= '0;
                        state <= s_rd;
                    end
                end
                s_rd: state <= s_lat;
                s_lat: begin
                    col_cnt <= '0;
                    state <= s_col;
                end
                s_col: begin
                    if (int'(col_cnt) == img_w - 1) begin
                        if (int'(row_cnt) == img_h - 1) begin
                            state <= s_fin;
                        end else begin
                            row_cnt <= row_cnt + 1'b1;
                            state <= s_rd;
                        end
                    end else begin
                        col_cnt <= col_cnt + 1'b1;
                    end
                end
                s_fin: state <= s_idle;
                default: state <= s_idle;
            endcase
        end
    end

    // both memories answer one cycle after row_addr
    always_ff @(posedge clk) begin
        if (state == s_lat) begin
            img_row <= img_dout;
            blur_row <= blur_dout;
        end
    end

    assign row_addr = row_cnt;

    assign pix = img_row.pix[col_cnt];
    assign blur_pix = blur_row.pix[col_cnt];
    assign resp = $signed({{(feat_pkg::resp_w - feat_pkg::pix_w){1'b0}}, pix})
                - $signed({{(feat_pkg::resp_w - feat_pkg::pix_w){1'b0}}, blur_pix});
    assign hit = filter_on ? (resp > filter_threshold) : (resp > 0);

    assign kpt_we = (state == s_col) && hit;
    assign kpt_addr = kpt_count[feat_pkg::kpt_addr_w-1:0];
    assign kpt_din = {row_cnt, col_cnt};    // row high, column low
    assign detect_done = (state == s_fin);

    a_kpt_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        kpt_we |-> (int'(kpt_count) < feat_pkg::kpt_depth)
    );

endmodule

//--- rtl/feature_core.sv
module feature_core #(
    parameter int img_w = feat_pkg::img_w,
    parameter int img_h = feat_pkg::img_h
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               start,
    input  logic                               filter_on,
    input  logic signed [feat_pkg::resp_w-1:0] filter_threshold,
    input  logic                               img_we,
    input  logic [feat_pkg::row_addr_w-1:0]    img_addr_in,
    input  feat_pkg::row_word_t                img_din,
    input  logic [feat_pkg::kpt_addr_w-1:0]    kpt_addr_in,
    output logic [feat_pkg::kpt_w-1:0]         kpt_dout,
    output logic [feat_pkg::cnt_w-1:0]         kpt_count,
    output logic                               busy,
    output logic                               done
);

    feat_pkg::phase_t phase;
    logic host_sel;
    logic blur_start;
    logic detect_start;

    logic [feat_pkg::row_addr_w-1:0] img_addr;
    logic [feat_pkg::row_addr_w-1:0] blur_addr;
    logic [feat_pkg::kpt_addr_w-1:0] kpt_addr;
    feat_pkg::row_word_t img_dout;
    feat_pkg::row_word_t blur_dout;

    logic [feat_pkg::row_addr_w-1:0] gb_img_addr;
    logic gb_blur_we;
    logic [feat_pkg::row_addr_w-1:0] gb_blur_addr;
    feat_pkg::row_word_t gb_blur_din;
    logic gb_blur_done;

    logic [feat_pkg::row_addr_w-1:0] kd_row_addr;
    logic kd_kpt_we;
    logic [feat_pkg::kpt_addr_w-1:0] kd_kpt_addr;
    logic [feat_pkg::kpt_w-1:0] kd_kpt_din;
    logic kd_detect_done;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= feat_pkg::ph_idle;
            blur_start <= 1'b0;
            detect_start <= 1'b0;
        end else begin
            blur_start <= 1'b0;
            detect_start <= 1'b0;
            case (phase)
                feat_pkg::ph_idle, feat_pkg::ph_done: begin
                    if (start) begin
                        phase <= feat_pkg::ph_blur;
                        blur_start <= 1'b1;
                    end
                end
                feat_pkg::ph_blur: begin
                    if (gb_blur_done) begin
                        phase <= feat_pkg::ph_detect;
                        detect_start <= 1'b1;
                    end
                end
                feat_pkg::ph_detect: begin
                    if (kd_detect_done) begin
                        phase <= feat_pkg::ph_done;    // held until next start
                    end
                end
                default: phase <= feat_pkg::ph_idle;
            endcase
        end
    end

    assign host_sel = (phase == feat_pkg::ph_idle) || (phase == feat_pkg::ph_done);
    assign busy = !host_sel;
    assign done = (phase == feat_pkg::ph_done);

    always_comb begin
        img_addr = img_addr_in;
        blur_addr = '0;
        kpt_addr = kpt_addr_in;
        case (phase)
            feat_pkg::ph_blur: begin
                img_addr = gb_img_addr;
                blur_addr = gb_blur_addr;
                kpt_addr = '0;
            end
            feat_pkg::ph_detect: begin
                img_addr = kd_row_addr;    // same row from both memories
                blur_addr = kd_row_addr;
                kpt_addr = kd_kpt_addr;
            end
            default: ;
        endcase
    end

    row_mem #(.data_w(feat_pkg::row_w), .depth(img_h)) img_mem (
        .clk  (clk),
        .we   (img_we && host_sel),
        .addr (img_addr),
        .din  (img_din.flat),
        .dout (img_dout.flat)
    );

    row_mem #(.data_w(feat_pkg::row_w), .depth(img_h)) blur_mem (
        .clk  (clk),
        .we   (gb_blur_we),
        .addr (blur_addr),
        .din  (gb_blur_din.flat),
        .dout (blur_dout.flat)
    );

    row_mem #(.data_w(feat_pkg::kpt_w), .depth(feat_pkg::kpt_depth)) kpt_mem (
        .clk  (clk),
        .we   (kd_kpt_we),
        .addr (kpt_addr),
        .din  (kd_kpt_din),
        .dout (kpt_dout)
    );

    gaussian_blur #(.img_w(img_w), .img_h(img_h)) gaussian_blur_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .blur_start (blur_start),
        .img_dout   (img_dout),
        .img_addr   (gb_img_addr),
        .blur_we    (gb_blur_we),
        .blur_addr  (gb_blur_addr),
        .blur_din   (gb_blur_din),
        .blur_done  (gb_blur_done)
    );

    keypoint_detect #(.img_w(img_w), .img_h(img_h)) keypoint_detect_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .detect_start     (detect_start),
        .filter_on        (filter_on),
        .filter_threshold (filter_threshold),
        .img_dout         (img_dout),
        .blur_dout        (blur_dout),
        .row_addr         (kd_row_addr),
        .kpt_we           (kd_kpt_we),
        .kpt_addr         (kd_kpt_addr),
        .kpt_din          (kd_kpt_din),
        .kpt_count        (kpt_count),
        .detect_done      (kd_detect_done)
    );

    // engines stay quiet while the host owns the memories
    a_idle_no_engine_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        (phase == feat_pkg::ph_idle) |-> !(gb_blur_we || kd_kpt_we)
    );

endmodule

//--- verification/tb_feature_core.sv
module tb_feature_core;

    localparam int img_w = feat_pkg::img_w;
    localparam int img_h = feat_pkg::img_h;
    localparam int pix_w = feat_pkg::pix_w;
    localparam int n_tests = 8;
    localparam int done_timeout = 5000;

    // image kinds
    localparam int k_zero = 0;
    localparam int k_const = 1;
    localparam int k_single = 2;
    localparam int k_random = 3;
    localparam int k_keep = 4;    // same image as the previous entry

    logic clk = 1'b0;
    logic rst_n;
    logic start;
    logic filter_on;
    logic signed [feat_pkg::resp_w-1:0] filter_threshold;
    logic img_we;
    logic [feat_pkg::row_addr_w-1:0] img_addr_in;
    feat_pkg::row_word_t img_din;
    logic [feat_pkg::kpt_addr_w-1:0] kpt_addr_in;
    logic [feat_pkg::kpt_w-1:0] kpt_dout;
    logic [feat_pkg::cnt_w-1:0] kpt_count;
    logic busy;
    logic done;

    int kind_tab [n_tests];
    int fon_tab [n_tests];
    int thr_tab [n_tests];
    int cnt_tab [n_tests];    // -1 when the image kind does not fix it

    logic [pix_w-1:0] image [img_h][img_w];
    logic [15:0] lfsr_state;
    logic [feat_pkg::kpt_w-1:0] exp_kpt [$];

    feature_core #(.img_w(img_w), .img_h(img_h)) feature_core_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .start            (start),
        .filter_on        (filter_on),
        .filter_threshold (filter_threshold),
        .img_we           (img_we),
        .img_addr_in      (img_addr_in),
        .img_din          (img_din),
        .kpt_addr_in      (kpt_addr_in),
        .kpt_dout         (kpt_dout),
        .kpt_count        (kpt_count),
        .busy             (busy),
        .done             (done)
    );

    always #5 clk = ~clk;

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hb400;
        end
        return s >> 1;
    endfunction

    task automatic take_pixel(output logic [pix_w-1:0] p);
        for (int b = 0; b < pix_w; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            p[b] = lfsr_state[0];    // one step per bit
        end
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
            $display("Verification failed");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    task automatic make_image(input int kind);
        for (int r = 0; r < img_h; r++) begin
            for (int c = 0; c < img_w; c++) begin
                if (kind == k_const) begin
                    image[r][c] = 8'd100;
                end else if (kind == k_random) begin
                    take_pixel(image[r][c]);
                end else if (kind != k_keep) begin
                    image[r][c] = '0;
                end
            end
        end
        if (kind == k_single) begin
            image[5][9] = 8'd200;
        end
    endtask

    task automatic write_image();
        for (int r = 0; r < img_h; r++) begin
            @(negedge clk);
            img_we = 1'b1;
            img_addr_in = feat_pkg::row_addr_w'(r);
            for (int c = 0; c < img_w; c++) begin
                img_din.pix[c] = image[r][c];
            end
        end
        @(negedge clk);
        img_we = 1'b0;
    endtask

    // 1 2 1 / 2 4 2 / 1 2 1, zero outside the image, truncated / 16
    function automatic int blur_ref(input int r, input int c);
        int sum;
        int w;
        sum = 0;
        for (int dr = -1; dr <= 1; dr++) begin
            for (int dc = -1; dc <= 1; dc++) begin
                if (r + dr >= 0 && r + dr < img_h && c + dc >= 0 && c + dc < img_w) begin
                    w = ((dr == 0) ? 2 : 1) * ((dc == 0) ? 2 : 1);
                    sum = sum + w * int'(image[r + dr][c + dc]);
                end
            end
        end
        return sum / 16;
    endfunction

    task automatic build_expected(input int fon, input int thr);
        int resp;
        exp_kpt.delete();
        for (int r = 0; r < img_h; r++) begin
            for (int c = 0; c < img_w; c++) begin
                resp = int'(image[r][c]) - blur_ref(r, c);
                if ((fon != 0 && resp > thr) || (fon == 0 && resp > 0)) begin
                    exp_kpt.push_back(feat_pkg::kpt_w'((r << feat_pkg::col_w) | c));
                end
            end
        end
    endtask

    task automatic run_and_wait();
        int cycles;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        cycles = 0;
        while (!done) begin
            compare_value("busy", busy, 1);
            if (cycles == done_timeout) begin
                $display("timeout: done did not rise within %0d cycles", done_timeout);
                $display("Verification failed");
                $fatal(1, "no done");
            end
            cycles++;
            @(negedge clk);
        end
        compare_value("busy", busy, 0);
    endtask

    task automatic read_back();
        compare_value("kpt_count", kpt_count, exp_kpt.size());
        for (int i = 0; i < exp_kpt.size(); i++) begin
            @(negedge clk);
            kpt_addr_in = feat_pkg::kpt_addr_w'(i);
            @(negedge clk);    // registered read
            compare_value("kpt_dout", kpt_dout, exp_kpt[i]);
        end
    endtask

    initial begin
        rst_n = 1'b0;
        start = 1'b0;
        filter_on = 1'b0;
        filter_threshold = '0;
        img_we = 1'b0;
        img_addr_in = '0;
        img_din = '0;
        kpt_addr_in = '0;
        lfsr_state = 16'd39;

        kind_tab = '{k_zero, k_const, k_single, k_random, k_random, k_keep, k_random, k_random};
        fon_tab = '{0, 0, 1, 1, 1, 1, 0, 1};
        thr_tab = '{0, 0, 149, 20, -30, -30, 0, -100};
        cnt_tab = '{0, 60, 1, -1, -1, -1, -1, -1};    // 60 border pixels

        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        compare_value("busy", busy, 0);
        compare_value("done", done, 0);
        compare_value("kpt_count", kpt_count, 0);

        for (int t = 0; t < n_tests; t++) begin
            make_image(kind_tab[t]);
            if (kind_tab[t] != k_keep) begin
                write_image();
            end
            filter_on = (fon_tab[t] != 0);
            filter_threshold = feat_pkg::resp_w'(thr_tab[t]);
            build_expected(fon_tab[t], thr_tab[t]);
            run_and_wait();
            if (cnt_tab[t] >= 0) begin
                compare_value("kpt_count", kpt_count, cnt_tab[t]);
            end
            read_back();
        end

        $display("Verification passed");
        $finish;
    end

endmodule

//--- sources.f
rtl/feat_pkg.sv
rtl/row_mem.sv
rtl/line_buffer.sv
rtl/gaussian_blur.sv
rtl/keypoint_detect.sv
rtl/feature_core.sv
verification/tb_feature_core.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the feature_core testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
    -f sources.f \
    --top-module tb_feature_core \
    -o tb_feature_core

./obj_dir/tb_feature_core > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
if ! grep -q "Verification passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation PASSED"
